/* logic/rv_decode_pkg.sv */
package rv_decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [5:0]  funct6_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  op_t;
    typedef logic [3:0]  alu_func_t;

    // field positions inside the instruction word
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int F7_LSB  = 25;
    localparam int F6_LSB  = 26;  // immediate shifts carry a 6-bit shamt on rv64

    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // alu funct3 values shared by the immediate and register forms
    localparam funct3_t F3_ADD  = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010, F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100, F3_SR  = 3'b101, F3_OR  = 3'b110, F3_AND  = 3'b111;

    localparam funct3_t F3_LB   = 3'b000, F3_LH  = 3'b001, F3_LW  = 3'b010, F3_LD   = 3'b011;
    localparam funct3_t F3_LBU  = 3'b100, F3_LHU = 3'b101, F3_LWU = 3'b110;
    localparam funct3_t F3_SB   = 3'b000, F3_SH  = 3'b001, F3_SW  = 3'b010, F3_SD   = 3'b011;

    localparam funct3_t F3_JALR = 3'b000;
    localparam funct3_t F3_BEQ  = 3'b000, F3_BNE  = 3'b001, F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111;

    localparam funct3_t F3_CSRRW  = 3'b001, F3_CSRRS  = 3'b010, F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101, F3_CSRRSI = 3'b110, F3_CSRRCI = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub / sra
    localparam funct6_t F6_BASE = 6'b000000;
    localparam funct6_t F6_ALT  = 6'b010000;   // srai

    localparam op_t OP_NONE  = 6'd0;
    localparam op_t OP_ADDI  = 6'd1,  OP_SLTI  = 6'd2,  OP_SLTIU = 6'd3;
    localparam op_t OP_XORI  = 6'd4,  OP_ORI   = 6'd5,  OP_ANDI  = 6'd6;
    localparam op_t OP_SLLI  = 6'd7,  OP_SRLI  = 6'd8,  OP_SRAI  = 6'd9;
    localparam op_t OP_ADD   = 6'd10, OP_SUB   = 6'd11, OP_SLL   = 6'd12;
    localparam op_t OP_SLT   = 6'd13, OP_SLTU  = 6'd14, OP_XOR   = 6'd15;
    localparam op_t OP_SRL   = 6'd16, OP_SRA   = 6'd17, OP_OR    = 6'd18;
    localparam op_t OP_AND   = 6'd19;
    localparam op_t OP_LB    = 6'd20, OP_LH    = 6'd21, OP_LW    = 6'd22;
    localparam op_t OP_LD    = 6'd23, OP_LBU   = 6'd24, OP_LHU   = 6'd25;
    localparam op_t OP_LWU   = 6'd26;
    localparam op_t OP_SB    = 6'd27, OP_SH    = 6'd28, OP_SW    = 6'd29;
    localparam op_t OP_SD    = 6'd30;
    localparam op_t OP_LUI   = 6'd31, OP_AUIPC = 6'd32, OP_JAL   = 6'd33;
    localparam op_t OP_JALR  = 6'd34;
    localparam op_t OP_BEQ   = 6'd35, OP_BNE   = 6'd36, OP_BLT   = 6'd37;
    localparam op_t OP_BGE   = 6'd38, OP_BLTU  = 6'd39, OP_BGEU  = 6'd40;
    localparam op_t OP_CSRRW = 6'd41, OP_CSRRS = 6'd42, OP_CSRRC = 6'd43;
    localparam op_t OP_CSRRWI = 6'd44, OP_CSRRSI = 6'd45, OP_CSRRCI = 6'd46;

    localparam alu_func_t ALU_NOP    = 4'd0;
    localparam alu_func_t ALU_ADD    = 4'd1;
    localparam alu_func_t ALU_SUB    = 4'd2;
    localparam alu_func_t ALU_AND    = 4'd3;
    localparam alu_func_t ALU_OR     = 4'd4;
    localparam alu_func_t ALU_XOR    = 4'd5;
    localparam alu_func_t ALU_LT     = 4'd6;
    localparam alu_func_t ALU_LTU    = 4'd7;
    localparam alu_func_t ALU_SL     = 4'd8;
    localparam alu_func_t ALU_SR     = 4'd9;   // arithmetic
    localparam alu_func_t ALU_SRU    = 4'd10;  // logical
    localparam alu_func_t ALU_DIRECT = 4'd11;  // pass operand through

    typedef struct packed {
        op_t       op;
        alu_func_t alufunc;
        logic      regwrite;
        logic      memwrite;
        logic      csr_read;
        logic      csr_write;
    } ctl_t;

endpackage

/* logic/alu_op_decoder.sv */
`timescale 1ns/100ps

module alu_op_decoder
    import rv_decode_pkg::*;
(
    input  instr_t instr,
    output ctl_t   ctl
);

    funct3_t   funct3;
    funct7_t   funct7;
    funct6_t   funct6;
    logic      is_reg;  // register-register form
    logic      alt;     // sub / sra / srai encoding
    logic      legal;
    op_t       op;
    alu_func_t func;

    assign funct3 = instr[F3_LSB +: $bits(funct3_t)];
    assign funct7 = instr[F7_LSB +: $bits(funct7_t)];
    assign funct6 = instr[F6_LSB +: $bits(funct6_t)];
    assign is_reg = instr[5];
    assign alt    = is_reg ? (funct7 == F7_ALT) : (funct6 == F6_ALT);

    // plain immediate ops carry immediate bits in the upper field
    always_comb begin
        if (is_reg) begin
            legal = (funct7 == F7_BASE) ||
                    ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
        end else if (funct3 == F3_SLL) begin
            legal = (funct6 == F6_BASE);
        end else if (funct3 == F3_SR) begin
            legal = (funct6 == F6_BASE) || (funct6 == F6_ALT);
        end else begin
            legal = 1'b1;
        end
    end

    always_comb begin
        op   = OP_NONE;
        func = ALU_NOP;
        unique case (funct3)
            F3_ADD: begin
                op   = !is_reg ? OP_ADDI : (alt ? OP_SUB : OP_ADD);
                func = (is_reg && alt) ? ALU_SUB : ALU_ADD;  // no subi
            end
            F3_SLL: begin
                op   = is_reg ? OP_SLL : OP_SLLI;
                func = ALU_SL;
            end
            F3_SLT: begin
                op   = is_reg ? OP_SLT : OP_SLTI;
                func = ALU_LT;
            end
            F3_SLTU: begin
                op   = is_reg ? OP_SLTU : OP_SLTIU;
                func = ALU_LTU;
            end
            F3_XOR: begin
                op   = is_reg ? OP_XOR : OP_XORI;
                func = ALU_XOR;
            end
            F3_SR: begin
                op   = is_reg ? (alt ? OP_SRA : OP_SRL) : (alt ? OP_SRAI : OP_SRLI);
                func = alt ? ALU_SR : ALU_SRU;
            end
            F3_OR: begin
                op   = is_reg ? OP_OR : OP_ORI;
                func = ALU_OR;
            end
            F3_AND: begin
                op   = is_reg ? OP_AND : OP_ANDI;
                func = ALU_AND;
            end
        endcase
    end

    always_comb begin
        ctl = '0;
        if (legal) begin
            ctl.op       = op;
            ctl.alufunc  = func;
            ctl.regwrite = 1'b1;
        end
    end

endmodule

/* logic/mem_op_decoder.sv */
`timescale 1ns/100ps

module mem_op_decoder
    import rv_decode_pkg::*;
(
    input  instr_t instr,
    output ctl_t   ctl
);

    funct3_t funct3;
    logic    is_store;
    op_t     op;

    assign funct3   = instr[F3_LSB +: $bits(funct3_t)];
    assign is_store = instr[5];

    always_comb begin
        op = OP_NONE;
        if (is_store) begin
            case (funct3)
                F3_SB:   op = OP_SB;
                F3_SH:   op = OP_SH;
                F3_SW:   op = OP_SW;
                F3_SD:   op = OP_SD;
                default: op = OP_NONE;
            endcase
        end else begin
            case (funct3)
                F3_LB:   op = OP_LB;
                F3_LH:   op = OP_LH;
                F3_LW:   op = OP_LW;
                F3_LD:   op = OP_LD;
                F3_LBU:  op = OP_LBU;
                F3_LHU:  op = OP_LHU;
                F3_LWU:  op = OP_LWU;
                default: op = OP_NONE;  // 3'b111 is reserved
            endcase
        end
    end

    always_comb begin
        ctl = '0;
        if (op != OP_NONE) begin
            ctl.op       = op;
            ctl.regwrite = !is_store;  // loads never write memory
            ctl.memwrite = is_store;
            ctl.alufunc  = is_store ? ALU_DIRECT : ALU_NOP;
        end
    end

endmodule

/* logic/flow_op_decoder.sv */
`timescale 1ns/100ps

module flow_op_decoder
    import rv_decode_pkg::*;
(
    input  instr_t instr,
    output ctl_t   ctl
);

    logic [4:0] group;  // opcode bits 6..2 within the flow group
    funct3_t    funct3;
    logic       is_branch;
    op_t        op;
    alu_func_t  func;

    assign group     = instr[6:2];
    assign funct3    = instr[F3_LSB +: $bits(funct3_t)];
    assign is_branch = (group == OPC_BRANCH[6:2]);

    always_comb begin
        op   = OP_NONE;
        func = ALU_NOP;
        case (group)
            OPC_LUI[6:2]: begin
                op   = OP_LUI;
                func = ALU_DIRECT;
            end
            OPC_AUIPC[6:2]: begin
                op   = OP_AUIPC;
                func = ALU_ADD;
            end
            OPC_JAL[6:2]: begin
                op   = OP_JAL;
                func = ALU_ADD;
            end
            OPC_JALR[6:2]: begin
                if (funct3 == F3_JALR) begin
                    op   = OP_JALR;
                    func = ALU_ADD;
                end
            end
            OPC_BRANCH[6:2]: begin
                case (funct3)
                    F3_BEQ:  op = OP_BEQ;
                    F3_BNE:  op = OP_BNE;
                    F3_BLT:  op = OP_BLT;
                    F3_BGE:  op = OP_BGE;
                    F3_BLTU: op = OP_BLTU;
                    F3_BGEU: op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            default: op = OP_NONE;
        endcase
    end

    // branches compare in the branch unit and write nothing back
    assign ctl = '{op: op, alufunc: func, regwrite: (op != OP_NONE) && !is_branch,
                   memwrite: 1'b0, csr_read: 1'b0, csr_write: 1'b0};

endmodule

/* logic/csr_op_decoder.sv */
`timescale 1ns/100ps

module csr_op_decoder
    import rv_decode_pkg::*;
(
    input  instr_t instr,
    output ctl_t   ctl
);

    funct3_t  funct3;
    reg_idx_t rd;
    reg_idx_t rs1;  // uimm for the immediate forms
    logic     is_swap;
    logic     is_set;
    op_t      op;

    assign funct3  = instr[F3_LSB +: $bits(funct3_t)];
    assign rd      = instr[RD_LSB +: $bits(reg_idx_t)];
    assign rs1     = instr[RS1_LSB +: $bits(reg_idx_t)];
    assign is_swap = (funct3 == F3_CSRRW) || (funct3 == F3_CSRRWI);
    assign is_set  = (funct3 == F3_CSRRS) || (funct3 == F3_CSRRSI);

    always_comb begin
        case (funct3)
            F3_CSRRW:  op = OP_CSRRW;
            F3_CSRRS:  op = OP_CSRRS;
            F3_CSRRC:  op = OP_CSRRC;
            F3_CSRRWI: op = OP_CSRRWI;
            F3_CSRRSI: op = OP_CSRRSI;
            F3_CSRRCI: op = OP_CSRRCI;
            default:   op = OP_NONE;  // ecall, ebreak and friends
        endcase
    end

    always_comb begin
        ctl = '0;
        if (op != OP_NONE) begin
            ctl.op       = op;
            ctl.csr_read = 1'b1;
            if (is_swap) begin
                ctl.alufunc   = ALU_DIRECT;
                ctl.regwrite  = (rd != '0);
                ctl.csr_write = 1'b1;
            end else begin
                ctl.alufunc   = is_set ? ALU_OR : ALU_AND;
                ctl.regwrite  = 1'b1;
                ctl.csr_write = (rs1 != '0);  // zero mask leaves the csr alone
            end
        end
    end

endmodule

/* logic/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode
    import rv_decode_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_valid,
    input  instr_t instr,
    output logic   ctl_valid,
    output ctl_t   ctl
);

    opcode_t opcode;
    ctl_t    alu_ctl;
    ctl_t    mem_ctl;
    ctl_t    flow_ctl;
    ctl_t    csr_ctl;
    ctl_t    sel_ctl;

    assign opcode = instr[$bits(opcode_t)-1:0];

    alu_op_decoder i_alu (
        .instr (instr),
        .ctl   (alu_ctl)
    );

    mem_op_decoder i_mem (
        .instr (instr),
        .ctl   (mem_ctl)
    );

    flow_op_decoder i_flow (
        .instr (instr),
        .ctl   (flow_ctl)
    );

    csr_op_decoder i_csr (
        .instr (instr),
        .ctl   (csr_ctl)
    );

    // group select on the full opcode so the w-forms fall to the default
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_OP:  sel_ctl = alu_ctl;
            OPC_LOAD, OPC_STORE: sel_ctl = mem_ctl;
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH: sel_ctl = flow_ctl;
            OPC_SYSTEM:          sel_ctl = csr_ctl;
            default:             sel_ctl = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl_valid <= 1'b0;
            ctl       <= '0;
        end else begin
            ctl_valid <= instr_valid;
            ctl       <= instr_valid ? sel_ctl : '0;  // idle cycles show a clean record
        end
    end

endmodule

/* dv/rv_decode_properties.sv */
`timescale 1ns/100ps

module rv_decode_properties
    import rv_decode_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic ctl_valid,
    input ctl_t ctl
);

    int n_errors = 0;  // failed assertions, read by the testbench

    // registered outputs come up clean one edge after reset
    a_reset_clears: assert property (@(posedge clk) rst |=> !ctl_valid && ctl == '0)
        else begin
            $error("ctl_valid or ctl not cleared in the cycle after reset");
            n_errors++;
        end

    a_write_has_op: assert property (@(posedge clk) disable iff (rst)
        (ctl.regwrite || ctl.memwrite) |-> ctl.op != OP_NONE)
        else begin
            $error("write enable set with no decoded operation");
            n_errors++;
        end

    a_one_write: assert property (@(posedge clk) disable iff (rst)
        !(ctl.regwrite && ctl.memwrite))
        else begin
            $error("regwrite and memwrite both set");
            n_errors++;
        end

    a_csr_rw: assert property (@(posedge clk) disable iff (rst)
        ctl.csr_write |-> ctl.csr_read)
        else begin
            $error("csr_write without csr_read");
            n_errors++;
        end

endmodule

bind rv_decode rv_decode_properties i_props (
    .clk       (clk),
    .rst       (rst),
    .ctl_valid (ctl_valid),
    .ctl       (ctl)
);

/* dv/rv_decode_tb.sv */
`timescale 1ns/100ps

module rv_decode_tb
    import rv_decode_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int DRIVEN = 20 + 12 + 11 + 25 + 18 + 68;  // alu, mem, flow, csr, illegal, timing
    localparam int MAX_CYCLES = RESET_CYCLES + 2 * DRIVEN + 50;

    logic   clk;
    logic   rst;
    logic   instr_valid;
    instr_t instr;
    logic   ctl_valid;
    ctl_t   ctl;

    logic [31:0] lfsr;
    logic        armed;      // outputs are known from here on
    logic        exp_valid;
    ctl_t        exp_ctl;
    instr_t      exp_instr;
    int          n_pass;
    int          n_fail;
    int          cycles = 0;

    // per-funct3 tables indexed by the funct3 value
    op_t imm_ops [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
    op_t reg_ops [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
    alu_func_t alu_fns [8] = '{ALU_ADD, ALU_SL, ALU_LT, ALU_LTU, ALU_XOR, ALU_SRU, ALU_OR, ALU_AND};
    op_t load_ops [8] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU, OP_NONE};
    op_t store_ops [8] = '{OP_SB, OP_SH, OP_SW, OP_SD, OP_NONE, OP_NONE, OP_NONE, OP_NONE};
    op_t branch_ops [8] = '{OP_BEQ, OP_BNE, OP_NONE, OP_NONE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    op_t csr_ops [8] = '{OP_NONE, OP_CSRRW, OP_CSRRS, OP_CSRRC,
                         OP_NONE, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    opcode_t opcodes [10] = '{OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_LUI,
                              OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_SYSTEM};

    rv_decode i_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctl_valid   (ctl_valid),
        .ctl         (ctl)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic instr_t make_instr(input opcode_t opc, input funct3_t f3);
        instr_t w;
        w = rand_bits(32);  // random rd, rs1, rs2 and immediate bits
        w[6:0] = opc;
        w[F3_LSB +: 3] = f3;
        return w;
    endfunction

    function automatic reg_idx_t nonzero_idx();
        reg_idx_t r;
        r = reg_idx_t'(rand_bits(5));
        if (r == '0) begin
            r = 5'd1;
        end
        return r;
    endfunction

    // expected control record for one instruction word
    function automatic ctl_t ref_ctl(input instr_t w);
        ctl_t    c;
        funct3_t f3;
        funct7_t f7;
        funct6_t f6;
        c  = '0;
        f3 = w[F3_LSB +: 3];
        f7 = w[31:25];
        f6 = w[31:26];
        case (w[6:0])
            OPC_OP_IMM: begin
                c.op       = imm_ops[f3];
                c.alufunc  = alu_fns[f3];
                c.regwrite = 1'b1;
                if (f3 == F3_SR && f6 == F6_ALT) begin
                    c.op      = OP_SRAI;
                    c.alufunc = ALU_SR;
                end else if ((f3 == F3_SLL || f3 == F3_SR) && f6 != F6_BASE) begin
                    c.op = OP_NONE;
                end
            end
            OPC_OP: begin
                c.op       = reg_ops[f3];
                c.alufunc  = alu_fns[f3];
                c.regwrite = 1'b1;
                if (f7 == F7_ALT && f3 == F3_ADD) begin
                    c.op      = OP_SUB;
                    c.alufunc = ALU_SUB;
                end else if (f7 == F7_ALT && f3 == F3_SR) begin
                    c.op      = OP_SRA;
                    c.alufunc = ALU_SR;
                end else if (f7 != F7_BASE) begin
                    c.op = OP_NONE;
                end
            end
            OPC_LOAD: begin
                c.op       = load_ops[f3];
                c.regwrite = 1'b1;
            end
            OPC_STORE: begin
                c.op       = store_ops[f3];
                c.alufunc  = ALU_DIRECT;
                c.memwrite = 1'b1;
            end
            OPC_LUI: begin
                c.op       = OP_LUI;
                c.alufunc  = ALU_DIRECT;
                c.regwrite = 1'b1;
            end
            OPC_AUIPC, OPC_JAL, OPC_JALR: begin
                c.op       = (w[6:0] == OPC_AUIPC) ? OP_AUIPC : (w[6:0] == OPC_JAL) ? OP_JAL :
                             (f3 == F3_JALR) ? OP_JALR : OP_NONE;
                c.alufunc  = ALU_ADD;
                c.regwrite = 1'b1;
            end
            OPC_BRANCH: c.op = branch_ops[f3];
            OPC_SYSTEM: begin
                c.op       = csr_ops[f3];
                c.csr_read = 1'b1;
                if (f3[1:0] == 2'b01) begin  // csrrw / csrrwi
                    c.alufunc   = ALU_DIRECT;
                    c.csr_write = 1'b1;
                    c.regwrite  = (w[RD_LSB +: 5] != '0);
                end else begin
                    c.alufunc   = (f3[1:0] == 2'b10) ? ALU_OR : ALU_AND;
                    c.regwrite  = 1'b1;
                    c.csr_write = (w[RS1_LSB +: 5] != '0);
                end
            end
            default: c = '0;
        endcase
        if (c.op == OP_NONE) begin
            c = '0;
        end
        return c;
    endfunction

    function automatic instr_t random_legal();
        instr_t w;
        for (int i = 0; i < 64; i++) begin
            w = make_instr(opcodes[rand_bits(4) % 10], funct3_t'(rand_bits(3)));
            if (ref_ctl(w) != '0) begin
                return w;
            end
        end
        return make_instr(OPC_OP_IMM, F3_ADD);
    endfunction

    task automatic check_ctl(input ctl_t got, input ctl_t exp);
        if (got === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("Error at %0t: instr %h gave op %0d alu %0d flags %b,",
                     $time, exp_instr, got.op, got.alufunc,
                     {got.regwrite, got.memwrite, got.csr_read, got.csr_write},
                     " expected op %0d alu %0d flags %b",
                     exp.op, exp.alufunc,
                     {exp.regwrite, exp.memwrite, exp.csr_read, exp.csr_write});
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("Error at %0t: ctl_valid is %b, expected %b (instr %h)",
                     $time, got, exp, exp_instr);
        end
    endtask

    // compare last cycle's result on the falling edge and drive the next inputs
    task automatic tick(input logic r, input logic v, input instr_t w, input ctl_t exp);
        @(negedge clk);
        if (armed) begin
            check_valid(ctl_valid, exp_valid);
            check_ctl(ctl, exp_ctl);
        end
        rst         = r;
        instr_valid = v;
        instr       = w;
        exp_valid   = !r && v;
        exp_ctl     = (!r && v) ? exp : '0;
        exp_instr   = w;
        armed       = 1'b1;
    endtask

    // compare the result of the final driven cycle
    task automatic check_last();
        @(negedge clk);
        check_valid(ctl_valid, exp_valid);
        check_ctl(ctl, exp_ctl);
    endtask

    task automatic send(input instr_t w);
        tick(1'b0, 1'b1, w, ref_ctl(w));
    endtask

    task automatic idle();
        tick(1'b0, 1'b0, instr_t'(rand_bits(32)), '0);
    endtask

    task automatic send_illegal(input opcode_t opc, input funct3_t f3, input funct7_t up);
        instr_t w;
        w = make_instr(opc, f3);
        w[31:25] = up;
        tick(1'b0, 1'b1, w, '0);  // valid stays high with an all-zero record
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (n_fail == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, n_fail - fails_before);
        end
    endtask

    task automatic alu_ops_test();
        int     fails;
        instr_t w;
        fails = n_fail;
        for (int f3 = 0; f3 < 8; f3++) begin
            w = make_instr(OPC_OP_IMM, funct3_t'(f3));
            if (f3 == F3_SLL || f3 == F3_SR) begin
                w[31:26] = F6_BASE;
            end
            send(w);
            if (f3 == F3_SR) begin
                w[31:26] = F6_ALT;
                send(w);
            end
            w = make_instr(OPC_OP, funct3_t'(f3));
            w[31:25] = F7_BASE;
            send(w);
            if (f3 == F3_ADD || f3 == F3_SR) begin
                w[31:25] = F7_ALT;
                send(w);
            end
        end
        idle();
        report_test("alu ops", fails);
    endtask

    task automatic mem_ops_test();
        int fails;
        fails = n_fail;
        for (int f3 = 0; f3 < 7; f3++) begin
            send(make_instr(OPC_LOAD, funct3_t'(f3)));
        end
        for (int f3 = 0; f3 < 4; f3++) begin
            send(make_instr(OPC_STORE, funct3_t'(f3)));
        end
        idle();
        report_test("memory ops", fails);
    endtask

    task automatic flow_ops_test();
        int fails;
        fails = n_fail;
        send(make_instr(OPC_LUI, funct3_t'(rand_bits(3))));
        send(make_instr(OPC_AUIPC, funct3_t'(rand_bits(3))));
        send(make_instr(OPC_JAL, funct3_t'(rand_bits(3))));
        send(make_instr(OPC_JALR, F3_JALR));
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                send(make_instr(OPC_BRANCH, funct3_t'(f3)));
            end
        end
        idle();
        report_test("control flow", fails);
    endtask

    task automatic csr_rules_test();
        int     fails;
        instr_t w;
        fails = n_fail;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 4; k++) begin
                if (f3 != 0 && f3 != 4) begin
                    w = make_instr(OPC_SYSTEM, funct3_t'(f3));
                    w[RD_LSB +: 5]  = k[0] ? nonzero_idx() : reg_idx_t'(0);
                    w[RS1_LSB +: 5] = k[1] ? nonzero_idx() : reg_idx_t'(0);
                    send(w);
                end
            end
        end
        idle();
        report_test("csr rules", fails);
    endtask

    task automatic illegal_test();
        int fails;
        fails = n_fail;
        send_illegal(OPC_OP_IMM, F3_SLL, 7'b0100000);
        send_illegal(OPC_OP_IMM, F3_SR, 7'b1000000);
        send_illegal(OPC_OP, F3_ADD, 7'b0000001);
        send_illegal(OPC_OP, F3_SLL, F7_ALT);
        send_illegal(OPC_OP, F3_OR, 7'b1000000);
        send_illegal(OPC_LOAD, 3'b111, funct7_t'(rand_bits(7)));
        send_illegal(OPC_STORE, 3'b100, funct7_t'(rand_bits(7)));
        send_illegal(OPC_STORE, 3'b111, funct7_t'(rand_bits(7)));
        send_illegal(OPC_JALR, 3'b001, funct7_t'(rand_bits(7)));
        send_illegal(OPC_BRANCH, 3'b010, funct7_t'(rand_bits(7)));
        send_illegal(OPC_BRANCH, 3'b011, funct7_t'(rand_bits(7)));
        send_illegal(OPC_SYSTEM, 3'b000, funct7_t'(rand_bits(7)));
        send_illegal(OPC_SYSTEM, 3'b100, funct7_t'(rand_bits(7)));
        send_illegal(7'b0011011, funct3_t'(rand_bits(3)), F7_BASE);  // op-imm-32
        send_illegal(7'b0111011, funct3_t'(rand_bits(3)), F7_BASE);  // op-32
        send_illegal(7'b0001111, funct3_t'(rand_bits(3)), funct7_t'(rand_bits(7)));
        send_illegal(7'b1111111, funct3_t'(rand_bits(3)), funct7_t'(rand_bits(7)));
        idle();
        report_test("illegal encodings", fails);
    endtask

    task automatic valid_timing_test();
        int fails;
        fails = n_fail;
        for (int i = 0; i < 64; i++) begin
            if (i == 32) begin
                repeat (3) tick(1'b1, 1'b1, random_legal(), '0);  // mid-run reset
            end
            if (rand_bits(2) == 0) begin
                idle();
            end else begin
                send(random_legal());
            end
        end
        idle();
        check_last();
        report_test("valid timing", fails);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'h6e88;
        armed       = 1'b0;
        exp_valid   = 1'b0;
        exp_ctl     = '0;
        exp_instr   = '0;
        n_pass      = 0;
        n_fail      = 0;
        repeat (RESET_CYCLES) tick(1'b1, 1'b0, '0, '0);
        alu_ops_test();
        mem_ops_test();
        flow_ops_test();
        csr_rules_test();
        illegal_test();
        valid_timing_test();
        n_fail += i_dut.i_props.n_errors;
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* rv_decode.f */
logic/rv_decode_pkg.sv
logic/alu_op_decoder.sv
logic/mem_op_decoder.sv
logic/flow_op_decoder.sv
logic/csr_op_decoder.sv
logic/rv_decode.sv
dv/rv_decode_properties.sv
dv/rv_decode_tb.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - files:
      - logic/rv_decode_pkg.sv
      - logic/alu_op_decoder.sv
      - logic/mem_op_decoder.sv
      - logic/flow_op_decoder.sv
      - logic/csr_op_decoder.sv
      - logic/rv_decode.sv
  - target: test
    files:
      - dv/rv_decode_properties.sv
      - dv/rv_decode_tb.sv
